// File: Makefile
TOP = tb_l2_cache_fa

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f flist.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir

// File: dv/l2_cache_cases.txt
# op addr wdata exp_data exp_hit, all hex
# op 0 read, 1 write, 2 read checked against exp_data, 3 external memory word equals exp_data
0 10 00000000 00000000 0
0 11 00000000 00000000 1
1 12 AABB0001 00000000 1
2 12 00000000 AABB0001 1
0 20 00000000 00000000 0
0 30 00000000 00000000 0
0 40 00000000 00000000 0
0 50 00000000 00000000 0
3 12 00000000 AABB0001 0
0 10 00000000 00000000 0
0 53 00000000 00000000 1
2 12 00000000 AABB0001 1
1 61 12345678 00000000 0
2 61 00000000 12345678 1
0 62 00000000 00000000 1
1 42 CAFE0042 00000000 1
0 70 00000000 00000000 0
3 42 00000000 CAFE0042 0
0 80 00000000 00000000 0
0 20 00000000 00000000 0
1 63 0BAD0063 00000000 1
0 90 00000000 00000000 0
3 61 00000000 12345678 0
3 63 00000000 0BAD0063 0

// File: dv/l2_cache_fa_assert.sv
`timescale 1ns/100ps
`default_nettype none

module l2_cache_fa_assert (
	input logic clock_bus_i,
	input logic resetn_i,
	input logic done_i,
	input logic write_i,
	input logic read_i,
	input logic req_i,
	input logic ready_req_i
);

	// core side, done is one cycle wide
	a_done_pulse: assert property (@(posedge clock_bus_i) disable iff (!resetn_i)
		done_i |=> !done_i)
		else $error("L1_done_o high for more than one cycle");

	// buffer side
	a_no_rw_overlap: assert property (@(posedge clock_bus_i) disable iff (!resetn_i)
		!(write_i && read_i))
		else $error("write_o and read_o high together");

	a_req_hold: assert property (@(posedge clock_bus_i) disable iff (!resetn_i)
		req_i && !ready_req_i |=> req_i)    // no withdraw before accept
		else $error("req_o dropped before ready_req_i");

endmodule

bind l2_cache_fa l2_cache_fa_assert i_assert (
	.clock_bus_i (clock_bus_i),
	.resetn_i    (resetn_i),
	.done_i      (L1_done_o),
	.write_i     (write_o),
	.read_i      (read_o),
	.req_i       (req_o),
	.ready_req_i (ready_req_i)
);

`default_nettype wire

// File: dv/tb_l2_cache_fa.sv
`timescale 1ns/100ps
`default_nettype none

module tb_l2_cache_fa;

	localparam int CAP       = 4;
	localparam int MAX_CASES = 64;

	logic                                   clock_bus_i;
	logic                                   resetn_i;
	logic [31:0]                            comm_i;
	cache_ctrl_pkg::metric_sel_e            metric_sel_i;
	logic [31:0]                            comm_o;
	logic                                   L1_req_i, L1_rw_i;
	logic [cache_cfg_pkg::BW_WORD_ADDR-1:0] L1_add_i;
	logic [cache_cfg_pkg::BW_DATA-1:0]      L1_data_i, L1_data_o;
	logic                                   L1_done_o, hit_o;
	logic                                   ready_req_i, ready_write_i, ready_read_i;
	logic [cache_cfg_pkg::BW_DATA-1:0]      data_i, data_o;
	logic                                   req_o, req_block_o, rw_o, write_o, read_o;
	logic [cache_cfg_pkg::BW_WORD_ADDR-1:0] add_o;

	l2_cache_fa #(.CACHE_BLOCK_CAPACITY(CAP)) i_dut (.*);

	// external memory and reference copy
	// --------------------
	logic [31:0] ext_mem [256];
	logic [31:0] shadow  [256];    // what every word should hold
	logic [31:0] rng;
	logic [7:0]  xfer_base;
	logic [1:0]  xfer_cnt;
	logic [8:0]  exp_req [$];      // {rw, block address} of each expected buffer request
	logic [8:0]  next_req;

	// replayed cases
	int          n_cases;
	bit          loaded;
	int          c_op   [MAX_CASES];
	logic [7:0]  c_addr [MAX_CASES];
	logic [31:0] c_wdat [MAX_CASES];
	logic [31:0] c_exp  [MAX_CASES];
	logic        c_hit  [MAX_CASES];

	// FIFO reference model
	logic [5:0] f_tag [CAP];
	logic       f_val [CAP];
	logic       f_dirty [CAP];
	int         f_ptr;
	int         n_hits, n_misses, n_wbs;

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	initial begin
		clock_bus_i = 1'b0;
		forever #50 clock_bus_i = ~clock_bus_i;    // 100 ns period
	end

	// buffer port model samples strobes mid cycle and drives 10 ns after the edge
	always @(negedge clock_bus_i) begin
		if (req_o && ready_req_i) begin
			if (exp_req.size() == 0) begin
				$display("buffer request seen while no miss needed one");
				$display("sim failed");
				$fatal(1);
			end
			next_req = exp_req.pop_front();
			check_bit("req_block_o", req_block_o, 1'b1);
			check_bit("rw_o", rw_o, next_req[8]);
			check_addr("add_o", add_o, next_req[7:0]);
			xfer_base = add_o;
			xfer_cnt  = '0;
		end
		if (write_o) begin
			ext_mem[xfer_base + 8'(xfer_cnt)] = data_o;
			xfer_cnt = xfer_cnt + 1'b1;
		end
		if (read_o) xfer_cnt = xfer_cnt + 1'b1;
		@(posedge clock_bus_i);
		#10;
		rng           = lcg_step(rng);
		ready_req_i   = rng[16];    // random gaps on every ready level
		ready_write_i = rng[18];
		ready_read_i  = rng[20];
		data_i        = ext_mem[xfer_base + 8'(xfer_cnt)];
	end

	// compare tasks
	// --------------------
	task automatic check_data(input string name, input logic [cache_cfg_pkg::BW_DATA-1:0] got,
			input logic [cache_cfg_pkg::BW_DATA-1:0] exp);
		if (got !== exp) begin
			$display("Error: %s got %h expected %h", name, got, exp);
			$display("sim failed");
			$fatal(1);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Error: %s got %h expected %h", name, got, exp);
			$display("sim failed");
			$fatal(1);
		end
	endtask

	task automatic check_count(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Error: %s got %h expected %h", name, got, exp);
			$display("sim failed");
			$fatal(1);
		end
	endtask

	task automatic check_addr(input string name,
			input logic [cache_cfg_pkg::BW_WORD_ADDR-1:0] got,
			input logic [cache_cfg_pkg::BW_WORD_ADDR-1:0] exp);
		if (got !== exp) begin
			$display("Error: %s got %h expected %h", name, got, exp);
			$display("sim failed");
			$fatal(1);
		end
	endtask

	// one core access held until the done pulse
	task automatic core_access(input logic rw, input logic [7:0] addr, input logic [31:0] wdata,
			output logic [31:0] rdata, output logic hit);
		L1_req_i  = 1'b1;
		L1_rw_i   = rw;
		L1_add_i  = addr;
		L1_data_i = wdata;
		do begin
			@(negedge clock_bus_i);
		end while (!L1_done_o);
		rdata = L1_data_o;    // stable in the done cycle
		hit   = hit_o;
		@(posedge clock_bus_i);
		#10;
		L1_req_i = 1'b0;
		@(posedge clock_bus_i);
		#10;
	endtask

	task automatic fifo_track(input logic [7:0] addr, input logic rw, input logic exp_hit);
		logic found;
		found = 1'b0;
		for (int i = 0; i < CAP; i++) begin
			if (f_val[i] && f_tag[i] == addr[7:2]) begin
				found = 1'b1;
				if (rw) f_dirty[i] = 1'b1;
			end
		end
		if (found !== exp_hit) begin
			$display("cases file hit bit for address %h disagrees with the FIFO rule", addr);
			$display("sim failed");
			$fatal(1);
		end
		if (found) n_hits++;
		else begin
			n_misses++;
			if (f_val[f_ptr] && f_dirty[f_ptr]) begin
				n_wbs++;    // dirty victim goes out
				exp_req.push_back({1'b1, f_tag[f_ptr], 2'b00});
			end
			exp_req.push_back({1'b0, addr[7:2], 2'b00});    // block fill
			f_tag[f_ptr]   = addr[7:2];
			f_val[f_ptr]   = 1'b1;
			f_dirty[f_ptr] = rw;
			f_ptr          = (f_ptr + 1) % CAP;
		end
	endtask

	task automatic load_cases();
		int    fd;
		string line;
		int    op, hit;
		logic [31:0] a, w, e;
		fd = $fopen("dv/l2_cache_cases.txt", "r");
		if (fd == 0) begin
			$display("could not open the cases file");
			$display("sim failed");
			$fatal(1);
		end
		n_cases = 0;
		while ($fgets(line, fd) > 0) begin
			if (line.len() > 1 && line.getc(0) != "#" &&
					$sscanf(line, "%h %h %h %h %h", op, a, w, e, hit) == 5) begin
				c_op[n_cases]   = op;
				c_addr[n_cases] = a[7:0];
				c_wdat[n_cases] = w;
				c_exp[n_cases]  = e;
				c_hit[n_cases]  = hit[0];
				n_cases++;
			end
		end
		$fclose(fd);
	endtask

	// watchdog allows 200 cycles per case
	initial begin
		wait (loaded);
		#(n_cases * 200 * 100);
		$display("timeout: the run did not finish in %0d cycles", n_cases * 200);
		$display("sim failed");
		$fatal(1);
	end

	// main sequence
	// --------------------
	initial begin
		logic [31:0] rdata;
		logic        hit;
		resetn_i      = 1'b0;
		comm_i        = '0;
		metric_sel_i  = cache_ctrl_pkg::HITS;
		L1_req_i      = 1'b0;
		L1_rw_i       = 1'b0;
		L1_add_i      = '0;
		L1_data_i     = '0;
		ready_req_i   = 1'b0;
		ready_write_i = 1'b0;
		ready_read_i  = 1'b0;
		data_i        = '0;
		xfer_base     = '0;
		xfer_cnt      = '0;
		rng = 32'd56014;
		for (int i = 0; i < 256; i++) begin
			rng        = lcg_step(rng);
			ext_mem[i] = rng ^ 32'(i);    // address folded in
			shadow[i]  = ext_mem[i];
		end
		for (int i = 0; i < CAP; i++) begin
			f_val[i]   = 1'b0;
			f_dirty[i] = 1'b0;
			f_tag[i]   = '0;
		end
		f_ptr    = 0;
		n_hits   = 0;
		n_misses = 0;
		n_wbs    = 0;
		load_cases();
		loaded = 1'b1;

		repeat (10) @(posedge clock_bus_i);
		#10 resetn_i = 1'b1;
		@(posedge clock_bus_i);
		#10;

		for (int k = 0; k < n_cases; k++) begin
			if (c_op[k] == 3) begin
				check_data("ext_mem", ext_mem[c_addr[k]], c_exp[k]);    // written back word
			end else begin
				fifo_track(c_addr[k], c_op[k] == 1, c_hit[k]);
				core_access(c_op[k] == 1, c_addr[k], c_wdat[k], rdata, hit);
				if (exp_req.size() != 0) begin
					$display("a buffer request for address %h never came", c_addr[k]);
					$display("sim failed");
					$fatal(1);
				end
				check_bit("hit_o", hit, c_hit[k]);
				if (c_op[k] == 1) shadow[c_addr[k]] = c_wdat[k];
				else check_data("L1_data_o", rdata, shadow[c_addr[k]]);
				if (c_op[k] == 2) check_data("L1_data_o", rdata, c_exp[k]);
			end
		end

		// counter readout then clear
		metric_sel_i = cache_ctrl_pkg::HITS;
		@(negedge clock_bus_i);
		check_count("comm_o hits", comm_o, 32'(n_hits));
		@(posedge clock_bus_i);
		#10 metric_sel_i = cache_ctrl_pkg::MISSES;
		@(negedge clock_bus_i);
		check_count("comm_o misses", comm_o, 32'(n_misses));
		@(posedge clock_bus_i);
		#10 metric_sel_i = cache_ctrl_pkg::WRITEBACKS;
		@(negedge clock_bus_i);
		check_count("comm_o writebacks", comm_o, 32'(n_wbs));
		@(posedge clock_bus_i);
		#10 comm_i = 32'(cache_ctrl_pkg::CLEAR);
		@(posedge clock_bus_i);
		#10 comm_i = 32'(cache_ctrl_pkg::NOP);
		for (int s = 0; s < 3; s++) begin
			metric_sel_i = cache_ctrl_pkg::metric_sel_e'(s);
			@(negedge clock_bus_i);
			check_count("comm_o cleared", comm_o, '0);
			@(posedge clock_bus_i);
			#10;
		end

		if (n_cases > 0) begin
			$display("sim passed");
			$finish;
		end else begin
			$display("sim failed");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire

// File: flist.f
source/cache_cfg_pkg.sv
source/cache_ctrl_pkg.sv
source/tag_memory_fa.sv
source/cache_data_mem.sv
source/cache_controller.sv
source/cache_perf_counters.sv
source/l2_cache_fa.sv
dv/l2_cache_fa_assert.sv
dv/tb_l2_cache_fa.sv

// File: source/cache_cfg_pkg.sv
`default_nettype none

package cache_cfg_pkg;

	// address layout
	// --------------------
	// a core word address is split as [tag|word], the tag alone
	// names a block since the cache is fully associative

	localparam int BW_WORD_ADDR = 8;                  // word address width
	localparam int BW_BLOCK     = 2;                  // word offset inside a block
	localparam int BW_TAG       = BW_WORD_ADDR - BW_BLOCK; // block tag width

	// sizes
	// --------------------
	localparam int BW_DATA         = 32;              // data word width
	localparam int WORDS_PER_BLOCK = 1 << BW_BLOCK;   // four words per block

endpackage

`default_nettype wire

// File: source/cache_controller.sv
`timescale 1ns/100ps
`default_nettype none

module cache_controller #(
	parameter int CACHE_BLOCK_CAPACITY = 4
)(
	input  logic                                    clock_bus_i,
	input  logic                                    resetn_i,

	// core side, req and rw come from the request register
	input  logic                                    L1_req_i,
	input  logic                                    L1_rw_i,       // 1 write, 0 read
	input  logic [cache_cfg_pkg::BW_TAG-1:0]        L1_tag_i,
	input  logic [cache_cfg_pkg::BW_BLOCK-1:0]      L1_word_i,
	input  logic [cache_cfg_pkg::BW_DATA-1:0]       L1_data_i,
	output logic                                    L1_done_o,
	output logic                                    L1_hit_o,
	output logic [cache_cfg_pkg::BW_DATA-1:0]       L1_data_o,

	// tag memory
	input  logic                                    cam_hit_i,
	input  logic [$clog2(CACHE_BLOCK_CAPACITY)-1:0] cam_addr_i,    // line that holds the tag
	input  logic [cache_cfg_pkg::BW_TAG-1:0]        cam_tag_i,     // tag at cam_addr_o
	output logic                                    cam_wren_o,
	output logic [$clog2(CACHE_BLOCK_CAPACITY)-1:0] cam_addr_o,
	output logic [cache_cfg_pkg::BW_TAG-1:0]        cam_tag_o,

	// data array
	input  logic [cache_cfg_pkg::BW_DATA-1:0]       cache_mem_data_i,
	output logic [$clog2(CACHE_BLOCK_CAPACITY)+cache_cfg_pkg::BW_BLOCK-1:0] cache_mem_add_o,
	output logic                                    cache_mem_rw_o,
	output logic [cache_cfg_pkg::BW_DATA-1:0]       cache_mem_data_o,

	// buffer port
	input  logic                                    mem_ready_i,   // request accepted
	output logic                                    mem_req_o,
	output logic                                    mem_req_block_o,
	output logic                                    mem_rw_o,
	output logic [cache_cfg_pkg::BW_WORD_ADDR-1:0]  mem_addr_o,
	input  logic                                    buffer_read_ready_i,
	input  logic [cache_cfg_pkg::BW_DATA-1:0]       buffer_data_i,
	output logic                                    buffer_read_ack_o,
	input  logic                                    buffer_write_ready_i,
	output logic                                    buffer_write_ack_o,
	output logic [cache_cfg_pkg::BW_DATA-1:0]       buffer_data_o,

	// performance events, one cycle each
	output logic                                    flag_hit_o,
	output logic                                    flag_miss_o,
	output logic                                    flag_writeback_o
);

	localparam int BW_LINE = $clog2(CACHE_BLOCK_CAPACITY);
	localparam int BW_BLK  = cache_cfg_pkg::BW_BLOCK;

	cache_ctrl_pkg::ctrl_state_e state_q, state_d;

	logic [BW_LINE-1:0]              ptr_q;      // FIFO victim pointer
	logic [CACHE_BLOCK_CAPACITY-1:0] dirty_q;    // one per line
	logic [BW_BLK-1:0]               cnt_q;      // word within the block transfer
	logic [BW_BLK-1:0]               cnt_inc;
	logic                            last_word;
	logic                            hit_q;      // hit bit for the current request
	logic                            miss_q;     // request already went through a fill
	logic                            skip_q;     // one idle cycle after SERVE

	assign cnt_inc   = cnt_q + 1'b1;
	assign last_word = (cnt_q == {BW_BLK{1'b1}});

	// next state and datapath steering
	// --------------------
	always_comb begin
		state_d            = state_q;
		cache_mem_add_o    = {cam_addr_i, L1_word_i};   // hit access by default
		cache_mem_rw_o     = 1'b0;
		cache_mem_data_o   = L1_data_i;
		cam_wren_o         = 1'b0;
		mem_req_o          = 1'b0;
		mem_rw_o           = 1'b0;
		mem_addr_o         = {L1_tag_i, {BW_BLK{1'b0}}};
		buffer_read_ack_o  = 1'b0;
		buffer_write_ack_o = 1'b0;
		flag_hit_o         = 1'b0;
		flag_miss_o        = 1'b0;
		flag_writeback_o   = 1'b0;

		case (state_q)
			cache_ctrl_pkg::IDLE: begin
				// registered req is stale right after a done
				if (L1_req_i && !skip_q) state_d = cache_ctrl_pkg::LOOKUP;
			end
			cache_ctrl_pkg::LOOKUP: begin
				if (cam_hit_i) begin
					cache_mem_rw_o = L1_rw_i;      // write hit, or pending write after a fill
					flag_hit_o     = !miss_q;      // the retry after a fill is not a hit
					state_d        = cache_ctrl_pkg::SERVE;
				end else begin
					flag_miss_o = 1'b1;
					state_d     = dirty_q[ptr_q] ? cache_ctrl_pkg::WB_REQ
					                             : cache_ctrl_pkg::FILL_REQ;
				end
			end
			cache_ctrl_pkg::WB_REQ: begin
				mem_req_o       = 1'b1;
				mem_rw_o        = 1'b1;
				mem_addr_o      = {cam_tag_i, {BW_BLK{1'b0}}};  // victim block address
				cache_mem_add_o = {ptr_q, {BW_BLK{1'b0}}};      // prefetch word 0
				if (mem_ready_i) state_d = cache_ctrl_pkg::WB_WRITE;
			end
			cache_ctrl_pkg::WB_WRITE: begin
				buffer_write_ack_o = buffer_write_ready_i;
				// array runs one word ahead, hold the word while not ready
				cache_mem_add_o = {ptr_q, buffer_write_ready_i ? cnt_inc : cnt_q};
				if (buffer_write_ready_i && last_word) begin
					flag_writeback_o = 1'b1;
					state_d          = cache_ctrl_pkg::FILL_REQ;
				end
			end
			cache_ctrl_pkg::FILL_REQ: begin
				mem_req_o = 1'b1;                // read, block address of the request
				if (mem_ready_i) state_d = cache_ctrl_pkg::FILL_READ;
			end
			cache_ctrl_pkg::FILL_READ: begin
				buffer_read_ack_o = buffer_read_ready_i;
				cache_mem_add_o   = {ptr_q, cnt_q};
				cache_mem_rw_o    = buffer_read_ready_i;
				cache_mem_data_o  = buffer_data_i;
				if (buffer_read_ready_i && last_word) begin
					cam_wren_o = 1'b1;           // tag the victim line with the new block
					state_d    = cache_ctrl_pkg::LOOKUP;  // retry now hits, applies the write
				end
			end
			cache_ctrl_pkg::SERVE: state_d = cache_ctrl_pkg::IDLE;
			default:               state_d = cache_ctrl_pkg::IDLE;
		endcase
	end

	// state and bookkeeping
	// --------------------
	always_ff @(posedge clock_bus_i) begin
		if (!resetn_i) begin
			state_q <= cache_ctrl_pkg::IDLE;
			ptr_q   <= '0;
			dirty_q <= '0;
			cnt_q   <= '0;
			hit_q   <= 1'b0;
			miss_q  <= 1'b0;
			skip_q  <= 1'b0;
		end else begin
			state_q <= state_d;
			skip_q  <= (state_q == cache_ctrl_pkg::SERVE);
			case (state_q)
				cache_ctrl_pkg::LOOKUP: begin
					if (cam_hit_i) begin
						hit_q <= !miss_q;
						if (L1_rw_i) dirty_q[cam_addr_i] <= 1'b1;
					end else begin
						miss_q <= 1'b1;
					end
				end
				cache_ctrl_pkg::WB_REQ, cache_ctrl_pkg::FILL_REQ: cnt_q <= '0;
				cache_ctrl_pkg::WB_WRITE: begin
					if (buffer_write_ready_i) cnt_q <= cnt_inc;
				end
				cache_ctrl_pkg::FILL_READ: begin
					if (buffer_read_ready_i) begin
						cnt_q <= cnt_inc;
						if (last_word) begin
							dirty_q[ptr_q] <= 1'b0;    // fresh block is clean
							// rotate to the next oldest line
							ptr_q <= (ptr_q == BW_LINE'(CACHE_BLOCK_CAPACITY - 1)) ? '0
							         : ptr_q + 1'b1;
						end
					end
				end
				cache_ctrl_pkg::SERVE: miss_q <= 1'b0;
				default: ;
			endcase
		end
	end

	// outputs
	// --------------------
	assign L1_done_o       = (state_q == cache_ctrl_pkg::SERVE);
	assign L1_hit_o        = hit_q;
	assign L1_data_o       = cache_mem_data_i;    // word read during LOOKUP
	assign buffer_data_o   = cache_mem_data_i;    // victim word, one read ahead
	assign mem_req_block_o = mem_req_o;           // every transfer is a whole block
	assign cam_addr_o      = ptr_q;               // victim line for tag read and write
	assign cam_tag_o       = L1_tag_i;

endmodule

`default_nettype wire

// File: source/cache_ctrl_pkg.sv
`default_nettype none

package cache_ctrl_pkg;

	// controller states
	// --------------------
	typedef enum logic [2:0] {
		IDLE      = 3'd0,  // wait for a registered core request
		LOOKUP    = 3'd1,  // tag search result is used, array read issued
		WB_REQ    = 3'd2,  // block write request to the buffer
		WB_WRITE  = 3'd3,  // stream the victim block out
		FILL_REQ  = 3'd4,  // block read request to the buffer
		FILL_READ = 3'd5,  // stream the new block in
		SERVE     = 3'd6   // done pulse to the core
	} ctrl_state_e;

	// counter readout select
	typedef enum logic [1:0] {
		HITS       = 2'd0,
		MISSES     = 2'd1,
		WRITEBACKS = 2'd2
	} metric_sel_e;

	// command opcodes, bit 0 of the comm port
	typedef enum logic {
		NOP   = 1'b0,
		CLEAR = 1'b1
	} comm_op_e;

endpackage

`default_nettype wire

// File: source/cache_data_mem.sv
`timescale 1ns/100ps
`default_nettype none

module cache_data_mem #(
	parameter int CACHE_BLOCK_CAPACITY = 4
)(
	input  logic                                                           clock_bus_i,
	input  logic                                                           wren_i,
	input  logic [$clog2(CACHE_BLOCK_CAPACITY)+cache_cfg_pkg::BW_BLOCK-1:0] add_i, // [line|word]
	input  logic [cache_cfg_pkg::BW_DATA-1:0]                              data_i,
	output logic [cache_cfg_pkg::BW_DATA-1:0]                              data_o
);

	localparam int DEPTH = CACHE_BLOCK_CAPACITY * cache_cfg_pkg::WORDS_PER_BLOCK;

	logic [cache_cfg_pkg::BW_DATA-1:0] mem_q [DEPTH];

	// single port, read data one cycle after the address
	always_ff @(posedge clock_bus_i) begin
		if (wren_i) begin
			mem_q[add_i] <= data_i;
		end
		data_o <= mem_q[add_i];    // old word on a write to the same address
	end

endmodule

`default_nettype wire

// File: source/cache_perf_counters.sv
`timescale 1ns/100ps
`default_nettype none

module cache_perf_counters (
	input  logic                        clock_bus_i,
	input  logic                        resetn_i,
	input  logic                        hit_i,          // event pulses from the controller
	input  logic                        miss_i,
	input  logic                        writeback_i,
	input  cache_ctrl_pkg::comm_op_e    comm_i,
	input  cache_ctrl_pkg::metric_sel_e metric_sel_i,
	output logic [31:0]                 comm_o
);

	logic [2:0]  event_w;
	logic [31:0] count_q [3];    // 0 hits, 1 misses, 2 writebacks

	assign event_w = {writeback_i, miss_i, hit_i};

	// counters
	// --------------------
	always_ff @(posedge clock_bus_i) begin
		if (!resetn_i || (comm_i == cache_ctrl_pkg::CLEAR)) begin
			for (int i = 0; i < 3; i++) begin
				count_q[i] <= '0;        // clear takes priority over a same-cycle event
			end
		end else begin
			for (int i = 0; i < 3; i++) begin
				if (event_w[i] && (count_q[i] != '1)) begin
					count_q[i] <= count_q[i] + 1'b1;    // saturate at all ones
				end
			end
		end
	end

	// readout
	// --------------------
	always_comb begin
		case (metric_sel_i)
			cache_ctrl_pkg::HITS:       comm_o = count_q[0];
			cache_ctrl_pkg::MISSES:     comm_o = count_q[1];
			cache_ctrl_pkg::WRITEBACKS: comm_o = count_q[2];
			default:                    comm_o = '0;    // unused select code
		endcase
	end

endmodule

`default_nettype wire

// File: source/l2_cache_fa.sv
`timescale 1ns/100ps
`default_nettype none

module l2_cache_fa #(
	parameter int CACHE_BLOCK_CAPACITY = 4
)(
	input  logic                                   clock_bus_i,
	input  logic                                   resetn_i,
	input  logic [31:0]                            comm_i,       // command, opcode in bit 0
	input  cache_ctrl_pkg::metric_sel_e            metric_sel_i,
	output logic [31:0]                            comm_o,       // selected counter

	// core
	input  logic                                   L1_req_i,     // held until L1_done_o
	input  logic                                   L1_rw_i,      // 1 write, 0 read
	input  logic [cache_cfg_pkg::BW_WORD_ADDR-1:0] L1_add_i,
	input  logic [cache_cfg_pkg::BW_DATA-1:0]      L1_data_i,
	output logic                                   L1_done_o,
	output logic [cache_cfg_pkg::BW_DATA-1:0]      L1_data_o,
	output logic                                   hit_o,

	// external memory buffer
	input  logic                                   ready_req_i,
	input  logic                                   ready_write_i,
	input  logic                                   ready_read_i,
	input  logic [cache_cfg_pkg::BW_DATA-1:0]      data_i,
	output logic                                   req_o,
	output logic                                   req_block_o,
	output logic                                   rw_o,
	output logic [cache_cfg_pkg::BW_WORD_ADDR-1:0] add_o,        // block aligned
	output logic                                   write_o,
	output logic                                   read_o,
	output logic [cache_cfg_pkg::BW_DATA-1:0]      data_o
);

	localparam int BW_LINE = $clog2(CACHE_BLOCK_CAPACITY);
	localparam int BW_CADD = BW_LINE + cache_cfg_pkg::BW_BLOCK;   // [line|word]

	// request register, gives the tag search a full cycle
	// --------------------
	logic L1_req_q, L1_rw_q;

	always_ff @(posedge clock_bus_i) begin
		if (!resetn_i) begin
			L1_req_q <= 1'b0;
			L1_rw_q  <= 1'b0;
		end else begin
			L1_req_q <= L1_req_i;
			L1_rw_q  <= L1_rw_i;
		end
	end

	logic [cache_cfg_pkg::BW_TAG-1:0]   req_tag;
	logic [cache_cfg_pkg::BW_BLOCK-1:0] req_word;

	assign req_tag  = L1_add_i[cache_cfg_pkg::BW_WORD_ADDR-1:cache_cfg_pkg::BW_BLOCK];
	assign req_word = L1_add_i[cache_cfg_pkg::BW_BLOCK-1:0];

	// internal nets
	logic                             cam_wren, cam_hit;
	logic [BW_LINE-1:0]               cam_line_wr, cam_line_hit;
	logic [cache_cfg_pkg::BW_TAG-1:0] cam_tag_wr, cam_tag_rd;
	logic                             mem_wren;
	logic [BW_CADD-1:0]               mem_add;
	logic [cache_cfg_pkg::BW_DATA-1:0] mem_wdata, mem_rdata;
	logic                             flag_hit, flag_miss, flag_wb;

	// blocks
	// --------------------
	tag_memory_fa #(.CACHE_BLOCK_CAPACITY(CACHE_BLOCK_CAPACITY)) u_tag (
		.clock_bus_i (clock_bus_i), .resetn_i (resetn_i),
		.wren_i      (cam_wren),    .tag_i    (req_tag),
		.wr_tag_i    (cam_tag_wr),  .add_i    (cam_line_wr),
		.add_o       (cam_line_hit), .tag_o   (cam_tag_rd),
		.hit_o       (cam_hit)
	);

	cache_data_mem #(.CACHE_BLOCK_CAPACITY(CACHE_BLOCK_CAPACITY)) u_data (
		.clock_bus_i (clock_bus_i), .wren_i (mem_wren),
		.add_i       (mem_add),     .data_i (mem_wdata),
		.data_o      (mem_rdata)
	);

	cache_controller #(.CACHE_BLOCK_CAPACITY(CACHE_BLOCK_CAPACITY)) u_ctrl (
		.clock_bus_i (clock_bus_i), .resetn_i (resetn_i),
		.L1_req_i (L1_req_q), .L1_rw_i (L1_rw_q), .L1_tag_i (req_tag),
		.L1_word_i (req_word), .L1_data_i (L1_data_i),
		.L1_done_o (L1_done_o), .L1_hit_o (hit_o), .L1_data_o (L1_data_o),
		.cam_hit_i (cam_hit), .cam_addr_i (cam_line_hit), .cam_tag_i (cam_tag_rd),
		.cam_wren_o (cam_wren), .cam_addr_o (cam_line_wr), .cam_tag_o (cam_tag_wr),
		.cache_mem_data_i (mem_rdata), .cache_mem_add_o (mem_add),
		.cache_mem_rw_o (mem_wren), .cache_mem_data_o (mem_wdata),
		.mem_ready_i (ready_req_i), .mem_req_o (req_o), .mem_req_block_o (req_block_o),
		.mem_rw_o (rw_o), .mem_addr_o (add_o),
		.buffer_read_ready_i (ready_read_i), .buffer_data_i (data_i),
		.buffer_read_ack_o (read_o), .buffer_write_ready_i (ready_write_i),
		.buffer_write_ack_o (write_o), .buffer_data_o (data_o),
		.flag_hit_o (flag_hit), .flag_miss_o (flag_miss), .flag_writeback_o (flag_wb)
	);

	cache_perf_counters u_perf (
		.clock_bus_i  (clock_bus_i), .resetn_i (resetn_i),
		.hit_i        (flag_hit),    .miss_i   (flag_miss), .writeback_i (flag_wb),
		.comm_i       (cache_ctrl_pkg::comm_op_e'(comm_i[0])),
		.metric_sel_i (metric_sel_i),
		.comm_o       (comm_o)
	);

endmodule

`default_nettype wire

// File: source/tag_memory_fa.sv
`timescale 1ns/100ps
`default_nettype none

module tag_memory_fa #(
	parameter int CACHE_BLOCK_CAPACITY = 4
)(
	input  logic                                    clock_bus_i,
	input  logic                                    resetn_i,
	input  logic                                    wren_i,     // write wr_tag_i at add_i
	input  logic [cache_cfg_pkg::BW_TAG-1:0]        tag_i,      // search key
	input  logic [cache_cfg_pkg::BW_TAG-1:0]        wr_tag_i,   // tag to store
	input  logic [$clog2(CACHE_BLOCK_CAPACITY)-1:0] add_i,      // line for read and write
	output logic [$clog2(CACHE_BLOCK_CAPACITY)-1:0] add_o,      // line holding tag_i
	output logic [cache_cfg_pkg::BW_TAG-1:0]        tag_o,      // tag stored at add_i
	output logic                                    hit_o       // tag_i found in a valid line
);

	localparam int BW_LINE = $clog2(CACHE_BLOCK_CAPACITY);

	logic [cache_cfg_pkg::BW_TAG-1:0] tags_q [CACHE_BLOCK_CAPACITY];
	logic [CACHE_BLOCK_CAPACITY-1:0]  valid_q;

	// storage
	// --------------------

	// valid bits are control state, cleared on reset
	always_ff @(posedge clock_bus_i) begin
		if (!resetn_i) begin
			valid_q <= '0;
		end else if (wren_i) begin
			valid_q[add_i] <= 1'b1;    // line becomes live once tagged
		end
	end

	always_ff @(posedge clock_bus_i) begin
		if (wren_i) begin
			tags_q[add_i] <= wr_tag_i;
		end
	end

	// content search
	// --------------------
	// every valid line is compared at once, at most one can match
	// because a tag is only written after it missed
	always_comb begin
		hit_o = 1'b0;
		add_o = '0;
		for (int i = 0; i < CACHE_BLOCK_CAPACITY; i++) begin
			if (valid_q[i] && (tags_q[i] == tag_i)) begin
				hit_o = 1'b1;
				add_o = BW_LINE'(i);    // encode the matching line
			end
		end
	end

	// indexed read, gives the victim block address for a writeback
	assign tag_o = tags_q[add_i];

endmodule

`default_nettype wire
